// File: hw/ks_consts.svh
`ifndef KS_CONSTS_SVH
`define KS_CONSTS_SVH

// operand width in bits.
`define KS_WIDTH 64

// prefix levels, log2 of the width.
`define KS_LEVELS 6

// pg stage, the prefix levels, then the sum stage.
`define KS_STAGES (`KS_LEVELS + 2)

`endif

// File: hw/ks_operand_pkg.sv
`include "ks_consts.svh"

package ks_operand_pkg;

    // one addend as seen on the adder ports.
    typedef logic [`KS_WIDTH-1:0] operand_t;

    // sum with the carry out as bit 64.
    typedef struct packed {
        logic                 cout;
        logic [`KS_WIDTH-1:0] sum;
    } result_t;

endpackage

// File: hw/ks_prefix_pkg.sv
`include "ks_consts.svh"

package ks_prefix_pkg;

    // word handed from one prefix stage to the next.
    typedef struct packed {
        // group generate, widens by the span at every level.
        logic [`KS_WIDTH-1:0] grp_g;
        // group propagate, same grouping as grp_g.
        logic [`KS_WIDTH-1:0] grp_p;
        // bitwise propagate, untouched until the sum stage.
        logic [`KS_WIDTH-1:0] bit_p;
        // carry into bit 0.
        logic                 cin;
    } pg_word_t;

endpackage

// File: hw/ks_pipe_ctrl.sv
`timescale 1ns/1ps
`include "ks_consts.svh"

module ks_pipe_ctrl (
    input  logic clk,
    input  logic reset,
    input  logic in_valid,
    input  logic out_ready,
    output logic advance,
    output logic out_valid
);

    // one bit per stage, bit 0 is the pg stage.
    logic [`KS_STAGES-1:0] stage_valid;

    // the whole pipe moves when the last slot is empty or being drained.
    // bubbles stay in place, so this one term is the only stall.
    assign advance = !stage_valid[`KS_STAGES-1] || out_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_valid <= '0;
        end else if (advance) begin
            stage_valid <= {stage_valid[`KS_STAGES-2:0], in_valid};
        end
    end

    // last stage holds the registered sum.
    assign out_valid = stage_valid[`KS_STAGES-1];

endmodule

// File: hw/ks_pg_gen.sv
`timescale 1ns/1ps
`include "ks_consts.svh"

module ks_pg_gen (
    input  logic                     clk,
    input  logic                     advance,
    input  ks_operand_pkg::operand_t a,
    input  ks_operand_pkg::operand_t b,
    input  logic                     cin,
    output ks_prefix_pkg::pg_word_t  pg
);
    import ks_prefix_pkg::*;

    logic [`KS_WIDTH-1:0] gen_bit;
    logic [`KS_WIDTH-1:0] prop_bit;
    pg_word_t             pg_next;

    // bitwise generate and propagate.
    assign gen_bit  = a & b;
    assign prop_bit = a ^ b;

    always_comb begin
        pg_next.grp_g = gen_bit;
        pg_next.grp_p = prop_bit;
        // cin folded into bit 0, so every group reaching bit 0 carries it.
        pg_next.grp_g[0] = gen_bit[0] | (prop_bit[0] & cin);
        pg_next.bit_p    = prop_bit;
        pg_next.cin      = cin;
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            pg <= pg_next;
        end
    end

endmodule

// File: hw/ks_prefix_level.sv
`timescale 1ns/1ps
`include "ks_consts.svh"

module ks_prefix_level #(
    parameter int span = 1
) (
    input  logic                    clk,
    input  logic                    advance,
    input  ks_prefix_pkg::pg_word_t pg_in,
    output ks_prefix_pkg::pg_word_t pg_out
);
    import ks_prefix_pkg::*;

    logic [`KS_WIDTH-1:0] g_next;
    logic [`KS_WIDTH-1:0] p_next;
    pg_word_t             pg_next;

    genvar i;
    generate
        for (i = 0; i < `KS_WIDTH; i++) begin : g_bit
            if (i >= span) begin : g_black
                // black combine with the group span positions below.
                assign g_next[i] = pg_in.grp_g[i]
                                 | (pg_in.grp_p[i] & pg_in.grp_g[i-span]);
                assign p_next[i] = pg_in.grp_p[i] & pg_in.grp_p[i-span];
            end else begin : g_done
                // group already reaches bit 0, the gray region.
                assign g_next[i] = pg_in.grp_g[i];
                assign p_next[i] = pg_in.grp_p[i];
            end
        end
    endgenerate

    always_comb begin
        pg_next.grp_g = g_next;
        pg_next.grp_p = p_next;
        pg_next.bit_p = pg_in.bit_p;
        pg_next.cin   = pg_in.cin;
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            pg_out <= pg_next;
        end
    end

endmodule

// File: hw/ks_sum_stage.sv
`timescale 1ns/1ps
`include "ks_consts.svh"

module ks_sum_stage (
    input  logic                    clk,
    input  logic                    advance,
    input  ks_prefix_pkg::pg_word_t pg,
    output ks_operand_pkg::result_t result
);
    import ks_operand_pkg::*;

    logic [`KS_WIDTH-1:0] carry;
    result_t              result_next;

    // carry into bit i is the final group generate of bit i-1.
    assign carry = {pg.grp_g[`KS_WIDTH-2:0], pg.cin};

    always_comb begin
        result_next.sum  = pg.bit_p ^ carry;
        // top group spans the full width, cin included.
        result_next.cout = pg.grp_g[`KS_WIDTH-1];
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            result <= result_next;
        end
    end

endmodule

// File: hw/kogge_stone_adder.sv
`timescale 1ns/1ps
`include "ks_consts.svh"

module kogge_stone_adder (
    input  logic                     clk,
    input  logic                     reset,
    input  ks_operand_pkg::operand_t a,
    input  ks_operand_pkg::operand_t b,
    input  logic                     cin,
    input  logic                     in_valid,
    output logic                     in_ready,
    output ks_operand_pkg::operand_t sum,
    output logic                     cout,
    output logic                     out_valid,
    input  logic                     out_ready
);
    import ks_operand_pkg::*;
    import ks_prefix_pkg::*;

    logic     advance;
    // level_pg[0] from the pg stage, level_pg[k] after prefix level k.
    pg_word_t level_pg [0:`KS_LEVELS];
    result_t  result;

    ks_pipe_ctrl u_ctrl (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .out_ready (out_ready),
        .advance   (advance),
        .out_valid (out_valid)
    );

    // a stalled pipe cannot take a new operand pair.
    assign in_ready = advance;

    ks_pg_gen u_pg_gen (
        .clk     (clk),
        .advance (advance),
        .a       (a),
        .b       (b),
        .cin     (cin),
        .pg      (level_pg[0])
    );

    // spans 1, 2, 4, 8, 16, 32.
    genvar lvl;
    generate
        for (lvl = 0; lvl < `KS_LEVELS; lvl++) begin : g_level
            ks_prefix_level #(
                .span (1 << lvl)
            ) u_level (
                .clk     (clk),
                .advance (advance),
                .pg_in   (level_pg[lvl]),
                .pg_out  (level_pg[lvl+1])
            );
        end
    endgenerate

    ks_sum_stage u_sum (
        .clk     (clk),
        .advance (advance),
        .pg      (level_pg[`KS_LEVELS]),
        .result  (result)
    );

    assign sum  = result.sum;
    assign cout = result.cout;

endmodule

// File: tb/ks_assert.sv
`timescale 1ns/1ps

module ks_assert (
    input logic                     clk,
    input logic                     reset,
    input logic                     in_ready,
    input ks_operand_pkg::operand_t sum,
    input logic                     cout,
    input logic                     out_valid,
    input logic                     out_ready
);

    // pipe comes out of reset empty.
    a_empty_after_reset: assert property (
        @(posedge clk) reset |=> !out_valid
    ) else $error("out_valid was high in the cycle after reset");

    // a stalled result holds until the sink takes it.
    a_hold_on_stall: assert property (
        @(posedge clk) disable iff (reset)
        (out_valid && !out_ready) |=> ($stable(sum) && $stable(cout) && out_valid)
    ) else $error("output changed while stalled by the sink");

    // nothing can block an empty last stage.
    a_ready_when_empty: assert property (
        @(posedge clk) disable iff (reset)
        !out_valid |-> in_ready
    ) else $error("in_ready was low with out_valid low");

endmodule

bind kogge_stone_adder ks_assert u_assert (
    .clk       (clk),
    .reset     (reset),
    .in_ready  (in_ready),
    .sum       (sum),
    .cout      (cout),
    .out_valid (out_valid),
    .out_ready (out_ready)
);

// File: tb/tb_kogge_stone.sv
`timescale 1ns/1ps
`include "ks_consts.svh"

module tb_kogge_stone;
    import ks_operand_pkg::*;

    localparam int TABLE_LEN       = 17;
    localparam int N_RANDOM        = 200;
    localparam int WATCHDOG_CYCLES = (TABLE_LEN + N_RANDOM + 100) * `KS_STAGES;

    logic     clk;
    logic     reset;
    operand_t a;
    operand_t b;
    logic     cin;
    logic     in_valid;
    logic     in_ready;
    operand_t sum;
    logic     cout;
    logic     out_valid;
    logic     out_ready;

    // directed vectors with their expected results.
    operand_t tbl_a    [TABLE_LEN];
    operand_t tbl_b    [TABLE_LEN];
    logic     tbl_cin  [TABLE_LEN];
    operand_t tbl_sum  [TABLE_LEN];
    logic     tbl_cout [TABLE_LEN];

    // scoreboard queues in issue order.
    result_t exp_q    [$];
    int      accept_q [$];

    int cycle_count;
    int last_out_cycle;
    bit have_last_out;
    bit check_latency;
    bit random_sink;
    int issued;
    int received;
    int num_errors;
    int num_checks;

    kogge_stone_adder UUT (
        .clk       (clk),
        .reset     (reset),
        .a         (a),
        .b         (b),
        .cin       (cin),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .sum       (sum),
        .cout      (cout),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    always #10 clk = ~clk;

    task automatic compare_value(input string name, input logic [64:0] actual,
                                 input logic [64:0] expected);
        num_checks++;
        if (actual !== expected) begin
            num_errors++;
            $display("error at %0d ns: %s is %0h, expected %0h",
                     $time, name, actual, expected);
        end
    endtask

    // 65-bit sum of both addends and the carry-in.
    function automatic result_t reference_add(input operand_t op_a, input operand_t op_b,
                                              input logic op_cin);
        logic [64:0] full;
        full = {1'b0, op_a} + {1'b0, op_b} + {64'b0, op_cin};
        return full;
    endfunction

    task automatic set_entry(input int idx, input operand_t ea, input operand_t eb,
                             input logic ecin, input operand_t esum, input logic ecout);
        tbl_a[idx]    = ea;
        tbl_b[idx]    = eb;
        tbl_cin[idx]  = ecin;
        tbl_sum[idx]  = esum;
        tbl_cout[idx] = ecout;
    endtask

    task automatic load_table();
        set_entry(0, 64'h0, 64'h0, 1'b0, 64'h0, 1'b0);
        // ripple through the full width.
        set_entry(1, 64'hFFFF_FFFF_FFFF_FFFF, 64'h1, 1'b0, 64'h0, 1'b1);
        set_entry(2, 64'hFFFF_FFFF_FFFF_FFFF, 64'hFFFF_FFFF_FFFF_FFFF, 1'b1,
                  64'hFFFF_FFFF_FFFF_FFFF, 1'b1);
        set_entry(3, 64'hAAAA_AAAA_AAAA_AAAA, 64'h5555_5555_5555_5555, 1'b0,
                  64'hFFFF_FFFF_FFFF_FFFF, 1'b0);
        set_entry(4, 64'hAAAA_AAAA_AAAA_AAAA, 64'h5555_5555_5555_5555, 1'b1,
                  64'h0, 1'b1);
        set_entry(5, 64'hAAAA_AAAA_AAAA_AAAA, 64'hAAAA_AAAA_AAAA_AAAA, 1'b0,
                  64'h5555_5555_5555_5554, 1'b1);
        // one carry chain ending at each span boundary.
        set_entry(6, 64'h1, 64'h1, 1'b0, 64'h2, 1'b0);
        set_entry(7, 64'h3, 64'h1, 1'b0, 64'h4, 1'b0);
        set_entry(8, 64'hF, 64'h1, 1'b0, 64'h10, 1'b0);
        set_entry(9, 64'hFF, 64'h1, 1'b0, 64'h100, 1'b0);
        set_entry(10, 64'hFFFF, 64'h1, 1'b0, 64'h1_0000, 1'b0);
        set_entry(11, 64'h0000_0000_FFFF_FFFF, 64'h0, 1'b1, 64'h0000_0001_0000_0000, 1'b0);
        set_entry(12, 64'hFFFF_FFFF_0000_0000, 64'h0000_0001_0000_0000, 1'b0, 64'h0, 1'b1);
        set_entry(13, 64'h7FFF_FFFF_FFFF_FFFF, 64'h1, 1'b0, 64'h8000_0000_0000_0000, 1'b0);
        set_entry(14, 64'h0123_4567_89AB_CDEF, 64'hFEDC_BA98_7654_3210, 1'b0,
                  64'hFFFF_FFFF_FFFF_FFFF, 1'b0);
        set_entry(15, 64'h0123_4567_89AB_CDEF, 64'hFEDC_BA98_7654_3210, 1'b1,
                  64'h0, 1'b1);
        set_entry(16, 64'h1234_5678_9ABC_DEF0, 64'h0FED_CBA9_8765_4321, 1'b0,
                  64'h2222_2222_2222_2211, 1'b0);
    endtask

    // called on a falling edge and returns on the falling edge after the transfer.
    task automatic send_operands(input operand_t op_a, input operand_t op_b,
                                 input logic op_cin, input result_t expected);
        exp_q.push_back(expected);
        issued++;
        a        = op_a;
        b        = op_b;
        cin      = op_cin;
        in_valid = 1'b1;
        @(posedge clk);
        while (!in_ready) begin
            @(posedge clk);
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic wait_for_drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
    endtask

    task automatic check_result();
        result_t expected;
        int      accepted_at;
        received++;
        if (exp_q.size() == 0 || accept_q.size() == 0) begin
            num_errors++;
            $display("a result left the adder at %0d ns with no operands outstanding",
                     $time);
        end else begin
            expected    = exp_q.pop_front();
            accepted_at = accept_q.pop_front();
            compare_value("sum", {1'b0, sum}, {1'b0, expected.sum});
            compare_value("cout", 65'(cout), 65'(expected.cout));
            if (check_latency) begin
                compare_value("latency", 65'(cycle_count - accepted_at), 65'(`KS_STAGES));
                if (have_last_out) begin
                    compare_value("output spacing", 65'(cycle_count - last_out_cycle),
                                  65'(1));
                end
            end
            last_out_cycle = cycle_count;
            have_last_out  = 1'b1;
        end
    endtask

    // monitor samples on the rising edge before the registers update.
    always @(posedge clk) begin
        if (!reset) begin
            if (in_valid && in_ready) begin
                accept_q.push_back(cycle_count);
            end
            if (out_valid && !out_ready) begin
                compare_value("in_ready while stalled", 65'(in_ready), 65'(1'b0));
            end
            if (out_valid && out_ready) begin
                check_result();
            end
        end
        cycle_count++;
    end

    // sink stalls about one cycle in three.
    always @(negedge clk) begin
        if (random_sink) begin
            out_ready = ($urandom % 3) != 0;
        end
    end

    initial begin
        operand_t op_a;
        operand_t op_b;
        logic     op_cin;

        void'($urandom(93));
        clk            = 1'b0;
        reset          = 1'b1;
        a              = '0;
        b              = '0;
        cin            = 1'b0;
        in_valid       = 1'b0;
        out_ready      = 1'b0;
        cycle_count    = 0;
        last_out_cycle = 0;
        have_last_out  = 1'b0;
        check_latency  = 1'b0;
        random_sink    = 1'b0;
        issued         = 0;
        received       = 0;
        num_errors     = 0;
        num_checks     = 0;
        load_table();

        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // empty pipe must accept even with the sink not ready.
        @(posedge clk);
        compare_value("out_valid after reset", 65'(out_valid), 65'(1'b0));
        compare_value("in_ready after reset", 65'(in_ready), 65'(1'b1));

        @(negedge clk);
        out_ready     = 1'b1;
        check_latency = 1'b1;
        for (int i = 0; i < TABLE_LEN; i++) begin
            send_operands(tbl_a[i], tbl_b[i], tbl_cin[i], {tbl_cout[i], tbl_sum[i]});
        end
        wait_for_drain();

        check_latency = 1'b0;
        random_sink   = 1'b1;
        @(negedge clk);
        for (int n = 0; n < N_RANDOM; n++) begin
            op_a   = {$urandom, $urandom};
            op_b   = {$urandom, $urandom};
            op_cin = 1'($urandom);
            if ($urandom % 4 == 0) begin
                @(negedge clk);
            end
            send_operands(op_a, op_b, op_cin, reference_add(op_a, op_b, op_cin));
        end
        wait_for_drain();

        // anything still coming out now would be a duplicate.
        repeat (2 * `KS_STAGES) @(posedge clk);
        compare_value("results received", 65'(received), 65'(issued));

        $display("checks: %0d, errors: %0d", num_checks, num_errors);
        if (num_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the adder stopped delivering results",
                 WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+hw
hw/ks_operand_pkg.sv
hw/ks_prefix_pkg.sv
hw/ks_pipe_ctrl.sv
hw/ks_pg_gen.sv
hw/ks_prefix_level.sv
hw/ks_sum_stage.sv
hw/kogge_stone_adder.sv
tb/ks_assert.sv
tb/tb_kogge_stone.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_kogge_stone
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the simulator status is ignored here; the log decides pass or fail.
run: compile
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
